//--- common/apogee_pkg.sv
/*
 * Apogee BK-01 / Radio-86RK bus model shared definitions.
 * Address and data words, device regions, RAM and download
 * write records, and the default timing parameters.
 */

package apogee_pkg;

	// ------------------------------------------------------------------
	// Basic words
	// ------------------------------------------------------------------
	typedef logic [15:0] addr_t;
	typedef logic [7:0]  byte_t;

	// Device that answers a CPU address
	typedef enum logic [2:0] {
		reg_ram,
		reg_rom,
		reg_pit,
		reg_ppa1,
		reg_ppa2,
		reg_crt,
		reg_none
	} region_e;

	// Decoded bus select, dma marks the DMA controller write window
	typedef struct packed {
		region_e region;
		logic    dma;
	} bus_sel_t;

	// One access on the RAM port
	typedef struct packed {
		logic  we;
		addr_t addr;
		byte_t data;
	} ram_wr_t;

	// One byte of the host download stream
	typedef struct packed {
		logic [15:0] offset;
		byte_t       data;
	} dl_wr_t;

	// ------------------------------------------------------------------
	// Constants and defaults
	// ------------------------------------------------------------------
	// 8080 JMP, placed at address 0 ahead of the start vector
	localparam byte_t JMP_OPCODE = 8'hC3;

	localparam int CPU_DIV_DEFAULT    = 54;
	localparam int PIX_DIV_DEFAULT    = 12;
	localparam int ERASE_DIV_DEFAULT  = 64;
	localparam int RESET_HOLD_DEFAULT = 15;

endpackage

//--- logic/clock_enables.sv
/*
 * Clock enable generator.
 * Derives the CPU F1/F2 phases, the timer strobe and the pixel
 * strobe from clk_sys, with a double-rate turbo mode.
 */

module clock_enables #(
	parameter int CPU_DIV = 54,
	parameter int PIX_DIV = 12
) (
	input  logic clk_sys,
	input  logic reset_key,
	input  logic turbo_i,
	output logic ce_f1_o,
	output logic ce_f2_o,
	output logic ce_pit_o,
	output logic ce_pix_o
);

	localparam int CPU_W = $clog2(CPU_DIV);
	localparam int PIX_W = $clog2(PIX_DIV);

	// Phase positions inside one CPU period
	localparam int F1_AT       = 0;
	localparam int F2_AT       = 13;
	localparam int PIT_AT      = 8;
	localparam int F1_TURBO_AT = 27;
	localparam int F2_TURBO_AT = 40;

	logic [CPU_W-1:0] cpu_cnt;
	logic [PIX_W-1:0] pix_cnt;
	logic             turbo;
	logic             f2_seen;

	// ------------------------------------------------------------------
	// CPU period counter and phase strobes
	// ------------------------------------------------------------------
	always_ff @(posedge clk_sys) begin
		if (reset_key) begin
			cpu_cnt  <= '0;
			turbo    <= 1'b0;
			ce_f1_o  <= 1'b0;
			ce_f2_o  <= 1'b0;
			ce_pit_o <= 1'b0;
		end else begin
			if (cpu_cnt == CPU_W'(CPU_DIV - 1)) begin
				cpu_cnt <= '0;
				// Rate only changes on a period boundary
				turbo   <= turbo_i;
			end else begin
				cpu_cnt <= cpu_cnt + 1'b1;
			end
			ce_f1_o  <= (cpu_cnt == CPU_W'(F1_AT)) |
				(turbo & (cpu_cnt == CPU_W'(F1_TURBO_AT)));
			ce_f2_o  <= (cpu_cnt == CPU_W'(F2_AT)) |
				(turbo & (cpu_cnt == CPU_W'(F2_TURBO_AT)));
			ce_pit_o <= (cpu_cnt == CPU_W'(PIT_AT));
		end
	end

	// Pixel strobe
	always_ff @(posedge clk_sys) begin
		if (reset_key) begin
			pix_cnt  <= '0;
			ce_pix_o <= 1'b0;
		end else begin
			if (pix_cnt == PIX_W'(PIX_DIV - 1))
				pix_cnt <= '0;
			else
				pix_cnt <= pix_cnt + 1'b1;
			ce_pix_o <= (pix_cnt == '0);
		end
	end

	// Set by F2 and cleared by F1
	always_ff @(posedge clk_sys) begin
		if (reset_key)
			f2_seen <= 1'b1;
		else if (ce_f1_o)
			f2_seen <= 1'b0;
		else if (ce_f2_o)
			f2_seen <= 1'b1;
	end

	// The 8080 phases must alternate and never overlap
	a_phase_order: assert property (@(posedge clk_sys) disable iff (reset_key)
		ce_f1_o |-> (f2_seen && !ce_f2_o));

endmodule

//--- logic/reset_seq.sv
/*
 * CPU reset sequencer.
 * Holds the CPU in reset during any request and for a fixed
 * number of cycles after the last one.
 */

module reset_seq #(
	parameter int RESET_HOLD = 15
) (
	input  logic clk_sys,
	input  logic reset_key,
	input  logic user_reset_i,
	input  logic filling_i,
	output logic cpu_reset_o
);

	localparam int HOLD_W = $clog2(RESET_HOLD + 1);

	logic [HOLD_W-1:0] hold_cnt;
	logic              reset_req;

	// Loading RAM keeps the CPU stopped as well
	assign reset_req = user_reset_i | filling_i;

	always_ff @(posedge clk_sys) begin
		if (reset_key) begin
			hold_cnt    <= '0;
			cpu_reset_o <= 1'b1;
		end else if (reset_req) begin
			hold_cnt    <= '0;
			cpu_reset_o <= 1'b1;
		end else if (hold_cnt != HOLD_W'(RESET_HOLD)) begin
			hold_cnt <= hold_cnt + 1'b1;
		end else begin
			// Counter saturated, let the CPU run
			cpu_reset_o <= 1'b0;
		end
	end

endmodule

//--- loader/rk_loader.sv
/*
 * RK tape-file loader.
 * Turns the host download stream into RAM writes: a JMP vector
 * at address 0, the file body at its start address, and then
 * zeroes over the rest of RAM up to the start address.
 */

module rk_loader #(
	parameter int ERASE_DIV = 64
) (
	input  logic              clk_sys,
	input  logic              reset_key,
	input  logic              dl_active_i,
	input  logic              dl_wr_i,
	input  logic [7:0]        dl_index_i,
	input  apogee_pkg::dl_wr_t  dl_i,
	output apogee_pkg::ram_wr_t fill_o,
	output logic              filling_o,
	output logic              mode86_o
);

	import apogee_pkg::*;

	// Divider is at least 2
	localparam int DIV_W = $clog2(ERASE_DIV);

	logic             active_q;
	logic             erase_pend;
	logic             erasing;
	logic [DIV_W-1:0] erase_div;

	addr_t   start_addr;
	addr_t   wr_ptr;
	addr_t   last_addr;
	addr_t   next_erase;
	ram_wr_t stage_q;

	// Pending trigger bridges the gap between download and erase
	assign filling_o  = dl_active_i | erase_pend | erasing;
	assign next_erase = last_addr + 16'd1;

	// ------------------------------------------------------------------
	// Download parser and erase walker
	// ------------------------------------------------------------------
	always_ff @(posedge clk_sys) begin
		if (reset_key) begin
			active_q   <= 1'b0;
			erase_pend <= 1'b0;
			erasing    <= 1'b0;
			erase_div  <= '0;
			mode86_o   <= 1'b0;
			stage_q.we <= 1'b0;
			fill_o.we  <= 1'b0;
		end else begin
			active_q   <= dl_active_i;
			stage_q.we <= 1'b0;
			// Second pipeline stage toward the RAM
			fill_o     <= stage_q;

			if (dl_active_i) begin
				if (!active_q)
					mode86_o <= (dl_index_i > 8'd1);
				erasing    <= 1'b0;
				erase_pend <= 1'b1;

				if (dl_wr_i) begin
					case (dl_i.offset)
						16'd0: begin
							// Leading sync byte, not stored
						end
						16'd1: begin
							start_addr[15:8] <= dl_i.data;
							stage_q          <= '{we: 1'b1, addr: 16'd0, data: JMP_OPCODE};
							last_addr        <= 16'd0;
						end
						16'd2: begin
							start_addr[7:0] <= dl_i.data;
							stage_q         <= '{we: 1'b1, addr: 16'd1, data: dl_i.data};
							last_addr       <= 16'd1;
						end
						16'd3: begin
							stage_q   <= '{we: 1'b1, addr: 16'd2, data: start_addr[15:8]};
							last_addr <= 16'd2;
						end
						16'd4: begin
							wr_ptr <= start_addr;
						end
						default: begin
							stage_q   <= '{we: 1'b1, addr: wr_ptr, data: dl_i.data};
							last_addr <= wr_ptr;
							wr_ptr    <= wr_ptr + 16'd1;
						end
					endcase
				end
			end else if (erase_pend) begin
				erase_pend <= 1'b0;
				erasing    <= 1'b1;
				erase_div  <= DIV_W'(1);
			end else if (erasing) begin
				if (erase_div == DIV_W'(ERASE_DIV - 1))
					erase_div <= '0;
				else
					erase_div <= erase_div + 1'b1;

				if (erase_div == '0) begin
					// Walk wraps at 64 KiB and stops at the start address
					if (next_erase == start_addr) begin
						erasing <= 1'b0;
					end else begin
						last_addr <= next_erase;
						// Keep the JMP vector
						stage_q <= '{we: (next_erase > 16'd2), addr: next_erase,
							data: 8'h00};
					end
				end
			end
		end
	end

	// Every write must reach the RAM while the loader owns it
	a_fill_owned: assert property (@(posedge clk_sys) disable iff (reset_key)
		fill_o.we |-> filling_o);

endmodule

//--- logic/map_decode.sv
/*
 * CPU address decoder.
 * Maps an address to its device region for the Apogee and
 * Radio-86 memory maps, with the startup ROM overlay.
 */

module map_decode (
	input  logic                 clk_sys,
	input  logic                 cpu_reset_i,
	input  logic                 mode86_i,
	input  apogee_pkg::addr_t    cpu_addr_i,
	output apogee_pkg::bus_sel_t sel_o
);

	import apogee_pkg::*;

	logic  startup;
	byte_t page;

	assign page = cpu_addr_i[15:8];

	// ROM overlays everything until the first jump into the upper half
	always_ff @(posedge clk_sys) begin
		startup <= cpu_reset_i | (startup & ~cpu_addr_i[15]);
	end

	// ------------------------------------------------------------------
	// Region decode
	// ------------------------------------------------------------------
	always_comb begin
		sel_o.region = reg_ram;
		sel_o.dma    = 1'b0;

		if (startup) begin
			sel_o.region = reg_rom;
		end else if (!mode86_i) begin
			// Apogee
			case (page) inside
				8'hEC: sel_o.region = reg_pit;
				8'hED: sel_o.region = reg_ppa1;
				8'hEE: sel_o.region = reg_ppa2;
				8'hEF: sel_o.region = reg_crt;
				[8'hF0:8'hFF]: begin
					sel_o.region = reg_rom;
					// DMA registers sit at F0xx only
					sel_o.dma    = (page == 8'hF0);
				end
				default: sel_o.region = reg_ram;
			endcase
		end else begin
			// Radio-86
			case (page) inside
				[8'h80:8'h9F]: sel_o.region = reg_ppa1;
				[8'hA0:8'hA7]: sel_o.region = reg_pit;
				[8'hA8:8'hBF]: sel_o.region = reg_none;
				[8'hC0:8'hDF]: sel_o.region = reg_crt;
				[8'hE0:8'hFF]: begin
					sel_o.region = reg_rom;
					sel_o.dma    = 1'b1;
				end
				default: sel_o.region = reg_ram;
			endcase
		end
	end

endmodule

//--- logic/main_ram.sv
/*
 * 64 KiB main RAM.
 * Loader port while filling, CPU port otherwise, one-cycle read.
 */

module main_ram (
	input  logic                clk_sys,
	input  apogee_pkg::ram_wr_t fill_i,
	input  logic                filling_i,
	input  logic                cpu_wr_i,
	input  apogee_pkg::addr_t   cpu_addr_i,
	input  apogee_pkg::byte_t   cpu_dout_i,
	output apogee_pkg::byte_t   rd_data_o
);

	import apogee_pkg::*;

	byte_t   mem [0:65535];
	addr_t   addr_q;
	ram_wr_t port;

	// Port mux
	always_comb begin
		if (filling_i) begin
			port = fill_i;
		end else begin
			port.we   = cpu_wr_i;
			port.addr = cpu_addr_i;
			port.data = cpu_dout_i;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (port.we)
			mem[port.addr] <= port.data;
		addr_q <= port.addr;
	end

	// Registered address, so a write shows up on the next read
	assign rd_data_o = mem[addr_q];

endmodule

//--- logic/apogee_core.sv
/*
 * Apogee BK-01 / Radio-86RK system bus top level.
 * Clock enables, reset, RK loader, address decode and main RAM.
 */

module apogee_core #(
	parameter int CPU_DIV    = apogee_pkg::CPU_DIV_DEFAULT,
	parameter int PIX_DIV    = apogee_pkg::PIX_DIV_DEFAULT,
	parameter int ERASE_DIV  = apogee_pkg::ERASE_DIV_DEFAULT,
	parameter int RESET_HOLD = apogee_pkg::RESET_HOLD_DEFAULT
) (
	input  logic                 clk_sys,
	input  logic                 reset_key,
	input  logic                 turbo_i,
	input  logic                 user_reset_i,
	input  logic                 dl_active_i,
	input  logic                 dl_wr_i,
	input  logic [7:0]           dl_index_i,
	input  apogee_pkg::dl_wr_t   dl_i,
	input  apogee_pkg::addr_t    cpu_addr_i,
	input  logic                 cpu_wr_i,
	input  apogee_pkg::byte_t    cpu_dout_i,
	output apogee_pkg::bus_sel_t sel_o,
	output apogee_pkg::byte_t    rd_data_o,
	output logic                 cpu_reset_o,
	output logic                 filling_o,
	output logic                 ce_f1_o,
	output logic                 ce_f2_o,
	output logic                 ce_pit_o,
	output logic                 ce_pix_o
);

	import apogee_pkg::*;

	ram_wr_t fill;
	logic    mode86;

	clock_enables #(.CPU_DIV(CPU_DIV), .PIX_DIV(PIX_DIV)) u_clock_enables (
		.clk_sys  (clk_sys),
		.reset_key(reset_key),
		.turbo_i  (turbo_i),
		.ce_f1_o  (ce_f1_o),
		.ce_f2_o  (ce_f2_o),
		.ce_pit_o (ce_pit_o),
		.ce_pix_o (ce_pix_o)
	);

	reset_seq #(.RESET_HOLD(RESET_HOLD)) u_reset_seq (
		.clk_sys     (clk_sys),
		.reset_key   (reset_key),
		.user_reset_i(user_reset_i),
		.filling_i   (filling_o),
		.cpu_reset_o (cpu_reset_o)
	);

	rk_loader #(.ERASE_DIV(ERASE_DIV)) u_rk_loader (
		.clk_sys    (clk_sys),
		.reset_key  (reset_key),
		.dl_active_i(dl_active_i),
		.dl_wr_i    (dl_wr_i),
		.dl_index_i (dl_index_i),
		.dl_i       (dl_i),
		.fill_o     (fill),
		.filling_o  (filling_o),
		.mode86_o   (mode86)
	);

	map_decode u_map_decode (
		.clk_sys    (clk_sys),
		.cpu_reset_i(cpu_reset_o),
		.mode86_i   (mode86),
		.cpu_addr_i (cpu_addr_i),
		.sel_o      (sel_o)
	);

	main_ram u_main_ram (
		.clk_sys   (clk_sys),
		.fill_i    (fill),
		.filling_i (filling_o),
		.cpu_wr_i  (cpu_wr_i),
		.cpu_addr_i(cpu_addr_i),
		.cpu_dout_i(cpu_dout_i),
		.rd_data_o (rd_data_o)
	);

endmodule

//--- bench/tb_clock.sv
/*
 * Testbench clock and reset source.
 */

module tb_clock #(
	parameter int PERIOD       = 40,
	parameter int RESET_CYCLES = 4
) (
	output logic clk_sys,
	output logic reset_key
);

	timeunit 1ns;
	timeprecision 1ps;

	initial begin
		clk_sys = 1'b0;
		forever #(PERIOD / 2) clk_sys = ~clk_sys;
	end

	// Release on a falling edge, like all other stimulus
	initial begin
		reset_key = 1'b1;
		repeat (RESET_CYCLES) @(posedge clk_sys);
		@(negedge clk_sys);
		reset_key = 1'b0;
	end

endmodule

//--- bench/tb_check.sv
/*
 * Testbench checker.
 * Compares DUT outputs with expected values, watches the CPU
 * reset around each RAM fill and keeps the error counts.
 */

module tb_check #(
	parameter int RESET_HOLD = 15
) (
	input logic                 clk_sys,
	input logic                 reset_key,
	input apogee_pkg::bus_sel_t sel_i,
	input apogee_pkg::byte_t    rd_data_i,
	input logic                 cpu_reset_i,
	input logic                 filling_i,
	input logic                 ce_f1_i,
	input logic                 ce_f2_i,
	input logic                 ce_pit_i,
	input logic                 ce_pix_i
);

	timeunit 1ns;
	timeprecision 1ps;

	import apogee_pkg::*;

	int   err_count = 0;
	int   err_mark = 0;
	int   pass_tests = 0;
	int   fail_tests = 0;
	int   releases = 0;
	int   hold_cnt;
	logic fill_q;
	logic armed;

	// ------------------------------------------------------------------
	// CPU reset watcher
	// ------------------------------------------------------------------
	always @(posedge clk_sys) begin
		if (reset_key) begin
			fill_q   <= 1'b0;
			armed    <= 1'b0;
			hold_cnt <= 0;
		end else begin
			fill_q <= filling_i;
			if (fill_q && !cpu_reset_i) begin
				$display("cpu_reset_o was released while the RAM was still filling");
				err_count++;
			end
			if (filling_i) begin
				armed    <= 1'b1;
				hold_cnt <= 0;
			end else if (armed) begin
				if (!cpu_reset_i) begin
					armed <= 1'b0;
					releases++;
					check_int("cpu_reset_o hold cycles", hold_cnt, RESET_HOLD + 1);
				end else begin
					hold_cnt <= hold_cnt + 1;
				end
			end
		end
	end

	task automatic check_rd(input addr_t addr, input byte_t exp);
		if (rd_data_i !== exp) begin
			$display("FAIL rd_data_o @%h: got %h exp %h", addr, rd_data_i, exp);
			err_count++;
		end
	endtask

	task automatic check_sel(input addr_t addr, input bus_sel_t exp);
		if (sel_i !== exp) begin
			$display("FAIL sel_o @%h: got %h exp %h", addr, sel_i, exp);
			err_count++;
		end
	endtask

	task automatic check_int(input string what, input int got, input int exp);
		if (got != exp) begin
			$display("FAIL %s: got %h exp %h", what, got, exp);
			err_count++;
		end
	endtask

	// Counts enable pulses at falling edges where they are stable
	task automatic check_enables(input int ncyc, input int f1, input int f2,
		input int pit, input int pix);
		int n_f1;
		int n_f2;
		int n_pit;
		int n_pix;
		n_f1  = 0;
		n_f2  = 0;
		n_pit = 0;
		n_pix = 0;
		repeat (ncyc) begin
			@(negedge clk_sys);
			n_f1  += int'(ce_f1_i);
			n_f2  += int'(ce_f2_i);
			n_pit += int'(ce_pit_i);
			n_pix += int'(ce_pix_i);
		end
		check_int("ce_f1_o pulses", n_f1, f1);
		check_int("ce_f2_o pulses", n_f2, f2);
		check_int("ce_pit_o pulses", n_pit, pit);
		check_int("ce_pix_o pulses", n_pix, pix);
	endtask

	task automatic test_done(input string name);
		if (err_count == err_mark) begin
			$display("test %-16s ok", name);
			pass_tests++;
		end else begin
			$display("test %-16s %0d error(s)", name, err_count - err_mark);
			fail_tests++;
		end
		err_mark = err_count;
	endtask

	task automatic report();
		$display("tests: %0d passed, %0d failed, %0d check errors",
			pass_tests, fail_tests, err_count);
	endtask

endmodule

//--- bench/tb_top.sv
/*
 * Testbench top for the Apogee bus model.
 * Downloads RK files, then checks RAM contents, erase, reset,
 * decoding in both maps and the clock enables.
 */

module tb_top;

	timeunit 1ns;
	timeprecision 1ps;

	import apogee_pkg::*;

	localparam int ERASE_DIV   = 2;
	localparam int CPU_DIV     = CPU_DIV_DEFAULT;
	localparam int PIX_DIV     = PIX_DIV_DEFAULT;
	localparam int RESET_HOLD  = RESET_HOLD_DEFAULT;
	localparam int FILE_LEN    = 12;
	localparam int NUM_FILES   = 2;
	localparam int DEC_ROWS    = 14;
	// Download plus a full 64 KiB erase per file, doubled, plus the clock tests
	localparam int CYCLE_LIMIT = NUM_FILES * (2 * FILE_LEN + 2 * 65536 * ERASE_DIV) + 20000;

	typedef struct packed {
		logic [7:0] index;
		addr_t      start;
	} file_row_t;

	typedef struct packed {
		addr_t    addr;
		bus_sel_t apo;
		bus_sel_t r86;
	} dec_row_t;

	logic clk_sys, reset_key, turbo, user_reset, dl_active, dl_wr, cpu_wr;
	logic [7:0] dl_index;
	dl_wr_t     dl;
	addr_t      cpu_addr;
	byte_t      cpu_dout, rd_data;
	bus_sel_t   sel;
	logic cpu_reset, filling, ce_f1, ce_f2, ce_pit, ce_pix;

	logic [31:0] lfsr_state;
	byte_t       file_bytes [FILE_LEN];
	int          cycles = 0;

	file_row_t file_table [NUM_FILES] = '{'{8'd1, 16'h3000}, '{8'd2, 16'h4100}};

	// Address, Apogee select, Radio-86 select
	dec_row_t dec_table [DEC_ROWS] = '{
		'{16'h0000, '{reg_ram, 1'b0}, '{reg_ram, 1'b0}},
		'{16'h7FFF, '{reg_ram, 1'b0}, '{reg_ram, 1'b0}},
		'{16'h8000, '{reg_ram, 1'b0}, '{reg_ppa1, 1'b0}},
		'{16'hA000, '{reg_ram, 1'b0}, '{reg_pit, 1'b0}},
		'{16'hA800, '{reg_ram, 1'b0}, '{reg_none, 1'b0}},
		'{16'hC000, '{reg_ram, 1'b0}, '{reg_crt, 1'b0}},
		'{16'hE000, '{reg_ram, 1'b0}, '{reg_rom, 1'b1}},
		'{16'hEC00, '{reg_pit, 1'b0}, '{reg_rom, 1'b1}},
		'{16'hED00, '{reg_ppa1, 1'b0}, '{reg_rom, 1'b1}},
		'{16'hEE00, '{reg_ppa2, 1'b0}, '{reg_rom, 1'b1}},
		'{16'hEF00, '{reg_crt, 1'b0}, '{reg_rom, 1'b1}},
		'{16'hF000, '{reg_rom, 1'b1}, '{reg_rom, 1'b1}},
		'{16'hF100, '{reg_rom, 1'b0}, '{reg_rom, 1'b1}},
		'{16'hFFFF, '{reg_rom, 1'b0}, '{reg_rom, 1'b1}}
	};

	tb_clock #(.PERIOD(40), .RESET_CYCLES(4)) clk0 (.clk_sys(clk_sys), .reset_key(reset_key));

	apogee_core #(.ERASE_DIV(ERASE_DIV)) dut0 (
		.clk_sys(clk_sys), .reset_key(reset_key), .turbo_i(turbo),
		.user_reset_i(user_reset), .dl_active_i(dl_active), .dl_wr_i(dl_wr),
		.dl_index_i(dl_index), .dl_i(dl), .cpu_addr_i(cpu_addr), .cpu_wr_i(cpu_wr),
		.cpu_dout_i(cpu_dout), .sel_o(sel), .rd_data_o(rd_data), .cpu_reset_o(cpu_reset),
		.filling_o(filling), .ce_f1_o(ce_f1), .ce_f2_o(ce_f2), .ce_pit_o(ce_pit),
		.ce_pix_o(ce_pix)
	);

	tb_check #(.RESET_HOLD(RESET_HOLD)) chk0 (
		.clk_sys(clk_sys), .reset_key(reset_key), .sel_i(sel), .rd_data_i(rd_data),
		.cpu_reset_i(cpu_reset), .filling_i(filling), .ce_f1_i(ce_f1), .ce_f2_i(ce_f2),
		.ce_pit_i(ce_pit), .ce_pix_i(ce_pix)
	);

	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
	endfunction

	// One LFSR step per bit
	task automatic take_byte(output byte_t b);
		for (int i = 0; i < 8; i++) begin
			b[i]       = lfsr_state[0];
			lfsr_state = lfsr_next(lfsr_state);
		end
	endtask

	// RK layout is sync, start hi/lo, end hi/lo and body
	task automatic build_file(input addr_t start);
		addr_t last;
		last          = start + 16'(FILE_LEN - 6);
		file_bytes[0] = 8'hE6;
		file_bytes[1] = start[15:8];
		file_bytes[2] = start[7:0];
		file_bytes[3] = last[15:8];
		file_bytes[4] = last[7:0];
		for (int i = 5; i < FILE_LEN; i++)
			take_byte(file_bytes[i]);
	endtask

	task automatic download(input file_row_t f);
		@(negedge clk_sys);
		dl_index  = f.index;
		dl_active = 1'b1;
		for (int i = 0; i < FILE_LEN; i++) begin
			@(negedge clk_sys);
			dl_wr     = 1'b1;
			dl.offset = 16'(i);
			dl.data   = file_bytes[i];
			@(negedge clk_sys);
			dl_wr = 1'b0;
		end
		@(negedge clk_sys);
		dl_active = 1'b0;
		// Erase length varies and the fall of filling marks its end
		while (filling)
			@(negedge clk_sys);
		while (cpu_reset)
			@(negedge clk_sys);
		@(posedge clk_sys);
		@(negedge clk_sys);
	endtask

	task automatic cpu_write(input addr_t a, input byte_t d);
		@(negedge clk_sys);
		cpu_addr = a;
		cpu_dout = d;
		cpu_wr   = 1'b1;
		@(negedge clk_sys);
		cpu_wr   = 1'b0;
		cpu_addr = 16'h0000;
	endtask

	task automatic cpu_read(input addr_t a, input byte_t exp);
		@(negedge clk_sys);
		cpu_addr = a;
		@(negedge clk_sys);
		chk0.check_rd(a, exp);
	endtask

	task automatic decode_check(input addr_t a, input bus_sel_t exp);
		@(negedge clk_sys);
		cpu_addr = a;
		#10;
		chk0.check_sel(a, exp);
	endtask

	// Timeout
	always @(posedge clk_sys) begin
		cycles++;
		if (cycles > CYCLE_LIMIT) begin
			$display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
			$display("** FAIL **");
			$finish;
		end
	end

	initial begin
		turbo      = 1'b0;
		user_reset = 1'b0;
		dl_active  = 1'b0;
		dl_wr      = 1'b0;
		dl_index   = 8'd0;
		dl         = '0;
		cpu_addr   = 16'h0000;
		cpu_wr     = 1'b0;
		cpu_dout   = 8'h00;
		lfsr_state = 32'h0bf6_0b88;

		@(posedge clk_sys);
		while (reset_key)
			@(posedge clk_sys);
		@(negedge clk_sys);

		// ------------------------------------------------------------------
		// Clock enables, normal and turbo
		// ------------------------------------------------------------------
		chk0.check_enables(10 * CPU_DIV, 10, 10, 10, 10 * CPU_DIV / PIX_DIV);
		chk0.test_done("clock_enables");
		turbo = 1'b1;
		repeat (2 * CPU_DIV) @(negedge clk_sys);
		chk0.check_enables(10 * CPU_DIV, 20, 20, 10, 10 * CPU_DIV / PIX_DIV);
		turbo = 1'b0;
		chk0.test_done("turbo");

		for (int f = 0; f < NUM_FILES; f++) begin
			cpu_write(16'h8000, 8'h5A);
			cpu_read(16'h8000, 8'h5A);
			cpu_addr = 16'h0000;
			build_file(file_table[f].start);
			download(file_table[f]);
			chk0.check_int("cpu_reset_o releases", chk0.releases, f + 1);
			chk0.test_done($sformatf("reset_%0d", f));

			// Overlay holds until the first access with bit 15 high
			for (int r = 0; r < DEC_ROWS; r++)
				if (!dec_table[r].addr[15])
					decode_check(dec_table[r].addr, '{reg_rom, 1'b0});
			@(negedge clk_sys);
			cpu_addr = 16'h8000;
			@(negedge clk_sys);
			chk0.test_done($sformatf("startup_%0d", f));

			for (int r = 0; r < DEC_ROWS; r++)
				decode_check(dec_table[r].addr,
					(file_table[f].index > 8'd1) ? dec_table[r].r86 : dec_table[r].apo);
			chk0.test_done($sformatf("decode_%0d", f));

			cpu_read(16'h0000, 8'hC3);
			cpu_read(16'h0001, file_table[f].start[7:0]);
			cpu_read(16'h0002, file_table[f].start[15:8]);
			for (int i = 5; i < FILE_LEN; i++)
				cpu_read(file_table[f].start + 16'(i - 5), file_bytes[i]);
			chk0.test_done($sformatf("contents_%0d", f));

			cpu_read(16'h8000, 8'h00);
			if (f > 0)
				cpu_read(file_table[f - 1].start, 8'h00);
			chk0.test_done($sformatf("erase_%0d", f));
		end

		chk0.report();
		if (chk0.err_count == 0)
			$display("** PASS **");
		else
			$display("** FAIL **");
		$finish;
	end

endmodule

//--- vlog.f
common/apogee_pkg.sv
logic/clock_enables.sv
logic/reset_seq.sv
loader/rk_loader.sv
logic/map_decode.sv
logic/main_ram.sv
logic/apogee_core.sv
bench/tb_clock.sv
bench/tb_check.sv
bench/tb_top.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
	--top-module tb_top -Mdir obj_dir -f vlog.f

out=$(./obj_dir/Vtb_top)
echo "$out"

if echo "$out" | grep -qxF '** PASS **'; then
	exit 0
fi
exit 1
